/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // primary opcodes
    localparam logic [5:0] SPE    = 6'b000000;
    localparam logic [5:0] REGIMM = 6'b000001;
    localparam logic [5:0] JAL    = 6'b000011;
    localparam logic [5:0] ADDI   = 6'b001000;
    localparam logic [5:0] ADDIU  = 6'b001001;
    localparam logic [5:0] SLTI   = 6'b001010;
    localparam logic [5:0] SLTIU  = 6'b001011;
    localparam logic [5:0] ANDI   = 6'b001100;
    localparam logic [5:0] ORI    = 6'b001101;
    localparam logic [5:0] XORI   = 6'b001110;
    localparam logic [5:0] LUI    = 6'b001111;
    localparam logic [5:0] COP0   = 6'b010000;
    localparam logic [5:0] SPE2   = 6'b011100;
    localparam logic [5:0] LB     = 6'b100000;
    localparam logic [5:0] LH     = 6'b100001;
    localparam logic [5:0] LW     = 6'b100011;
    localparam logic [5:0] LBU    = 6'b100100;
    localparam logic [5:0] LHU    = 6'b100101;
    localparam logic [5:0] SB     = 6'b101000;
    localparam logic [5:0] SH     = 6'b101001;
    localparam logic [5:0] SW     = 6'b101011;

    // function field, SPE unless noted
    localparam logic [5:0] SLL   = 6'b000000;
    localparam logic [5:0] SRL   = 6'b000010;
    localparam logic [5:0] MUL   = 6'b000010; // under SPE2
    localparam logic [5:0] SRA   = 6'b000011;
    localparam logic [5:0] SLLV  = 6'b000100;
    localparam logic [5:0] SRLV  = 6'b000110;
    localparam logic [5:0] SRAV  = 6'b000111;
    localparam logic [5:0] JALR  = 6'b001001;
    localparam logic [5:0] MFHI  = 6'b010000;
    localparam logic [5:0] MFLO  = 6'b010010;
    localparam logic [5:0] MULT  = 6'b011000;
    localparam logic [5:0] MULTU = 6'b011001;
    localparam logic [5:0] DIV   = 6'b011010;
    localparam logic [5:0] DIVU  = 6'b011011;
    localparam logic [5:0] ADD   = 6'b100000;
    localparam logic [5:0] ADDU  = 6'b100001;
    localparam logic [5:0] SUB   = 6'b100010;
    localparam logic [5:0] SUBU  = 6'b100011;
    localparam logic [5:0] AND_  = 6'b100100;
    localparam logic [5:0] OR_   = 6'b100101;
    localparam logic [5:0] XOR_  = 6'b100110;
    localparam logic [5:0] NOR_  = 6'b100111;
    localparam logic [5:0] SLT   = 6'b101010;
    localparam logic [5:0] SLTU  = 6'b101011;

    // rt field of REGIMM
    localparam logic [4:0] BLTZAL = 5'b10000;
    localparam logic [4:0] BGEZAL = 5'b10001;

    // bit 5 flags a pending exception, low bits are the cause
    localparam logic [5:0] EXC_NONE = 6'b000000;
    localparam logic [5:0] EXC_OV   = 6'b101100;

    localparam int MUL_CYCLES = 4;
    localparam int DIV_CYCLES = 33;

endpackage

`default_nettype wire

/* source/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // decoded instruction entering execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] val1;
        logic [31:0] val2;
        logic [31:0] valt; // store data
        logic [5:0]  icode;
        logic [5:0]  acode;
        logic [5:0]  exc_code;
        logic [4:0]  dst;
        logic [4:0]  rt;
        logic [4:0]  rs;
        logic        in_delay_slot;
    } id_ex_t;

    // execute result towards memory
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] val3;
        logic [31:0] valt;
        logic [5:0]  icode;
        logic [5:0]  acode;
        logic [5:0]  exc_code;
        logic [4:0]  dst;
        logic        in_delay_slot;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
        logic        hi_write;
        logic        lo_write;
    } hilo_t;

endpackage

`default_nettype wire

/* source/stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // stall wins over bubble so a held packet is never lost
    always_ff @(posedge clk) begin
        if (!resetn) begin
            q <= '0;
        end else if (stall) begin
            q <= q;
        end else if (bubble) begin
            q <= '0; // all zero reads as sll 0
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* source/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import isa_pkg::*, pipe_pkg::*;
(
    input  id_ex_t      cur,
    input  logic [31:0] hi,
    input  logic [31:0] lo,
    input  logic [31:0] mul_lo,
    output ex_mem_t     result
);

    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val3;
    logic [32:0] add_ext;
    logic [32:0] sub_ext;
    logic        overflow;

    assign a = cur.val1;
    assign b = cur.val2;

    // one extra sign bit, overflow when the top two bits differ
    assign add_ext = {a[31], a} + {b[31], b};
    assign sub_ext = {a[31], a} - {b[31], b};

    always_comb begin
        val3     = '0;
        overflow = 1'b0;
        case (cur.icode)
            ADDI: begin
                val3     = add_ext[31:0];
                overflow = add_ext[32] ^ add_ext[31];
            end
            ADDIU, LB, LBU, LH, LHU, LW, SB, SH, SW: val3 = a + b; // incl. address gen
            ANDI:  val3 = a & b;
            ORI:   val3 = a | b;
            XORI:  val3 = a ^ b;
            SLTI:  val3 = {31'b0, $signed(a) < $signed(b)};
            SLTIU: val3 = {31'b0, a < b};
            JAL:   val3 = b; // link address
            LUI:   val3 = b; // immediate already shifted
            COP0:  val3 = a; // mfc0
            SPE: begin
                case (cur.acode)
                    ADD: begin
                        val3     = add_ext[31:0];
                        overflow = add_ext[32] ^ add_ext[31];
                    end
                    SUB: begin
                        val3     = sub_ext[31:0];
                        overflow = sub_ext[32] ^ sub_ext[31];
                    end
                    ADDU: val3 = a + b;
                    SUBU: val3 = a - b;
                    AND_: val3 = a & b;
                    OR_:  val3 = a | b;
                    XOR_: val3 = a ^ b;
                    NOR_: val3 = ~(a | b);
                    SLL, SLLV: val3 = b << a[4:0];
                    SRL, SRLV: val3 = b >> a[4:0];
                    SRA, SRAV: val3 = $signed(b) >>> a[4:0];
                    SLT:  val3 = {31'b0, $signed(a) < $signed(b)};
                    SLTU: val3 = {31'b0, a < b};
                    JALR: val3 = b;
                    MFHI: val3 = hi;
                    MFLO: val3 = lo;
                    default: val3 = '0;
                endcase
            end
            SPE2: begin
                if (cur.acode == MUL) begin
                    val3 = mul_lo;
                end
            end
            REGIMM: begin
                if (cur.rt == BGEZAL || cur.rt == BLTZAL) begin
                    val3 = b;
                end
            end
            default: val3 = '0;
        endcase
    end

    always_comb begin
        result.pc            = cur.pc;
        result.val3          = val3;
        result.valt          = cur.valt;
        result.icode         = cur.icode;
        result.acode         = cur.acode;
        result.dst           = cur.dst;
        result.in_delay_slot = cur.in_delay_slot;
        // an older exception from fetch or decode takes precedence
        if (cur.exc_code[5]) begin
            result.exc_code = cur.exc_code;
        end else begin
            result.exc_code = overflow ? EXC_OV : EXC_NONE;
        end
    end

endmodule

`default_nettype wire

/* source/mul_multicycle.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_multicycle
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        done,
    output logic [63:0] c
);

    logic [MUL_CYCLES-1:0] vld;
    logic [31:0]           a_q;
    logic [31:0]           b_q;
    logic [63:0]           prod [MUL_CYCLES-1];

    // token walks alongside the product
    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else begin
            vld <= {vld[MUL_CYCLES-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
        end
        prod[0] <= 64'(a_q) * 64'(b_q);
        for (int i = 1; i < MUL_CYCLES - 1; i++) begin
            prod[i] <= prod[i-1]; // retiming slack
        end
    end

    assign done = vld[MUL_CYCLES-1];
    assign c    = prod[MUL_CYCLES-2];

endmodule

`default_nettype wire

/* source/div_multicycle.sv */
`timescale 1ns/1ps
`default_nettype none

module div_multicycle
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        start,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        done,
    output logic [63:0] c
);

    logic [31:0] rem_q;
    logic [31:0] quo_q; // dividend shifts out as quotient shifts in
    logic [31:0] dvs_q;
    logic [5:0]  cnt;
    logic        busy;
    logic [32:0] trial;

    // negative trial means the divisor does not fit
    assign trial = {rem_q, quo_q[31]} - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 6'(DIV_CYCLES - 1);
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // zero divisor always fits, giving all ones and the dividend back
    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a;
            dvs_q <= b;
        end else if (busy) begin
            if (trial[32]) begin
                rem_q <= {rem_q[30:0], quo_q[31]};
            end else begin
                rem_q <= trial[31:0];
            end
            quo_q <= {quo_q[30:0], ~trial[32]};
        end
    end

    assign c = {rem_q, quo_q};

endmodule

`default_nettype wire

/* source/muldiv_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  id_ex_t      cur,
    output logic        stall_req,
    output logic [31:0] hi,
    output logic [31:0] lo,
    output logic [31:0] mul_lo,
    output hilo_t       hilo_out
);

    logic        is_mul;
    logic        is_div;
    logic        is_signed;
    logic        is_md;
    logic        writes_hilo;
    logic        started;
    logic        finished;
    logic        start;
    logic        op_done;
    logic        mul_done;
    logic        div_done;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [63:0] mul_c;
    logic [63:0] div_c;
    logic [63:0] prod;
    logic [31:0] quo;
    logic [31:0] rem;

    always_comb begin
        is_mul = (cur.icode == SPE && (cur.acode == MULT || cur.acode == MULTU))
               || (cur.icode == SPE2 && cur.acode == MUL);
        is_div = cur.icode == SPE && (cur.acode == DIV || cur.acode == DIVU);
        is_signed = (cur.icode == SPE && (cur.acode == MULT || cur.acode == DIV))
                  || (cur.icode == SPE2 && cur.acode == MUL);
        is_md = is_mul || is_div;
        writes_hilo = is_md && cur.icode == SPE; // mul goes to a gpr instead
    end

    // magnitudes in, signs restored on the way out
    assign op_a = (is_signed && cur.val1[31]) ? -cur.val1 : cur.val1;
    assign op_b = (is_signed && cur.val2[31]) ? -cur.val2 : cur.val2;

    assign start     = is_md && !started;
    assign stall_req = is_md && !finished;
    assign op_done   = is_div ? div_done : mul_done;

    mul_multicycle u_mul (
        .clk    (clk),
        .resetn (resetn),
        .start  (start && is_mul),
        .a      (op_a),
        .b      (op_b),
        .done   (mul_done),
        .c      (mul_c)
    );

    div_multicycle u_div (
        .clk    (clk),
        .resetn (resetn),
        .start  (start && is_div),
        .a      (op_a),
        .b      (op_b),
        .done   (div_done),
        .c      (div_c)
    );

    assign prod = (is_signed && (cur.val1[31] ^ cur.val2[31])) ? -mul_c : mul_c;
    assign quo  = (is_signed && (cur.val1[31] ^ cur.val2[31])) ? -div_c[31:0] : div_c[31:0];
    assign rem  = (is_signed && cur.val1[31]) ? -div_c[63:32] : div_c[63:32]; // dividend sign

    // flags live only while the op sits in E
    always_ff @(posedge clk) begin
        if (!resetn || !stall_req) begin
            started  <= 1'b0;
            finished <= 1'b0;
        end else begin
            if (start) started <= 1'b1;
            if (op_done) finished <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hilo_out <= '0;
        end else begin
            hilo_out.hi_write <= 1'b0;
            hilo_out.lo_write <= 1'b0;
            if (op_done && writes_hilo) begin
                {hilo_out.hi, hilo_out.lo} <= is_div ? {rem, quo} : prod;
                hilo_out.hi_write          <= 1'b1;
                hilo_out.lo_write          <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_done && is_mul) begin
            mul_lo <= prod[31:0]; // read by alu once stall drops
        end
    end

    assign hi = hilo_out.hi;
    assign lo = hilo_out.lo;

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  id_ex_t  in_pkt,
    input  logic    bubble,
    output logic    stall_req,
    output ex_mem_t out_pkt,
    output hilo_t   hilo_out
);

    id_ex_t      cur;
    ex_mem_t     alu_result;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] mul_lo;

    stage_reg #(
        .payload_t (id_ex_t)
    ) ereg (
        .clk    (clk),
        .resetn (resetn),
        .stall  (stall_req),
        .bubble (bubble),
        .d      (in_pkt),
        .q      (cur)
    );

    exec_alu alu (
        .cur    (cur),
        .hi     (hi),
        .lo     (lo),
        .mul_lo (mul_lo),
        .result (alu_result)
    );

    muldiv_unit muldiv (
        .clk       (clk),
        .resetn    (resetn),
        .cur       (cur),
        .stall_req (stall_req),
        .hi        (hi),
        .lo        (lo),
        .mul_lo    (mul_lo),
        .hilo_out  (hilo_out)
    );

    // bubbles fill M while E waits on muldiv
    stage_reg #(
        .payload_t (ex_mem_t)
    ) mreg (
        .clk    (clk),
        .resetn (resetn),
        .stall  (1'b0),
        .bubble (stall_req),
        .d      (alu_result),
        .q      (out_pkt)
    );

endmodule

`default_nettype wire

/* test/execute_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage_props
    import isa_pkg::*, pipe_pkg::*;
(
    input logic    clk,
    input logic    resetn,
    input logic    stall_req,
    input ex_mem_t out_pkt
);

    logic [7:0] stall_cnt; // length of the current stall

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stall_cnt <= '0;
        end else if (stall_req) begin
            stall_cnt <= stall_cnt + 8'd1;
        end else begin
            stall_cnt <= '0;
        end
    end

    reset_clears_stall: assert property (@(posedge clk) !resetn |=> !stall_req)
        else $error("stall_req high right after reset");

    // the waiting instruction must not leak into M
    bubble_during_stall: assert property (
        @(posedge clk) disable iff (!resetn) stall_req |=> out_pkt == '0)
        else $error("out_pkt not a bubble while stalled");

    stall_bounded: assert property (
        @(posedge clk) disable iff (!resetn) stall_cnt <= DIV_CYCLES + 2)
        else $error("stall_req held too long");

endmodule

bind execute_stage execute_stage_props props_i (
    .clk       (clk),
    .resetn    (resetn),
    .stall_req (stall_req),
    .out_pkt   (out_pkt)
);

`default_nettype wire

/* test/execute_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb
    import isa_pkg::*, pipe_pkg::*;
;

    typedef struct packed {
        ex_mem_t     pkt;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        chk_hilo;
    } exp_t;

    localparam longint SMAX = 64'sh7fffffff;
    localparam longint SMIN = -SMAX - 1;
    localparam int     NUM_OPS = 34;
    localparam int     NUM_PKTS = 400;

    localparam logic [11:0] OP_TABLE [NUM_OPS] = '{
        {ADDI, 6'd0}, {ADDIU, 6'd0}, {ANDI, 6'd0}, {ORI, 6'd0}, {XORI, 6'd0},
        {SLTI, 6'd0}, {SLTIU, 6'd0}, {JAL, 6'd0}, {LUI, 6'd0}, {COP0, 6'd0},
        {LW, 6'd0}, {SB, 6'd0}, {REGIMM, 6'd0}, {SPE2, MUL},
        {SPE, ADD}, {SPE, ADDU}, {SPE, SUB}, {SPE, SUBU}, {SPE, AND_},
        {SPE, OR_}, {SPE, XOR_}, {SPE, NOR_}, {SPE, SLL}, {SPE, SRA},
        {SPE, SRLV}, {SPE, SLT}, {SPE, SLTU}, {SPE, JALR}, {SPE, MFHI},
        {SPE, MFLO}, {SPE, MULT}, {SPE, MULTU}, {SPE, DIV}, {SPE, DIVU}
    };

    logic        clk;
    logic        resetn;
    id_ex_t      in_pkt;
    logic        bubble;
    logic        stall_req;
    ex_mem_t     out_pkt;
    hilo_t       hilo_out;

    logic [31:0] rng_state = 32'hc692e3e0;
    logic [31:0] m_hi;
    logic [31:0] m_lo;
    exp_t        e_exp;   // model of the E register
    exp_t        out_exp; // what M should hold after this edge
    logic        chk_valid;

    execute_stage dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .in_pkt    (in_pkt),
        .bubble    (bubble),
        .stall_req (stall_req),
        .out_pkt   (out_pkt),
        .hilo_out  (hilo_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check32(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_out(input ex_mem_t e);
        check32("out_pkt.pc", out_pkt.pc, e.pc);
        check32("out_pkt.val3", out_pkt.val3, e.val3);
        check32("out_pkt.valt", out_pkt.valt, e.valt);
        check32("out_pkt.icode", 32'(out_pkt.icode), 32'(e.icode));
        check32("out_pkt.acode", 32'(out_pkt.acode), 32'(e.acode));
        check32("out_pkt.exc_code", 32'(out_pkt.exc_code), 32'(e.exc_code));
        check32("out_pkt.dst", 32'(out_pkt.dst), 32'(e.dst));
        check32("out_pkt.in_delay_slot", 32'(out_pkt.in_delay_slot), 32'(e.in_delay_slot));
    endtask

    // reference model, HI and LO follow program order
    task automatic predict(input id_ex_t p, output exp_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        ov;
        longint      sa;
        longint      sb;
        longint      s;
        logic [63:0] prod;
        a = p.val1;
        b = p.val2;
        r = '0;
        ov = 1'b0;
        e = '0;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        s = 0;
        case (p.icode)
            ADDI: begin
                s = sa + sb;
                r = s[31:0];
                ov = s > SMAX || s < SMIN;
            end
            ADDIU, LW, SB: r = a + b;
            ANDI:  r = a & b;
            ORI:   r = a | b;
            XORI:  r = a ^ b;
            SLTI:  r = (sa < sb) ? 32'd1 : 32'd0;
            SLTIU: r = (a < b) ? 32'd1 : 32'd0;
            JAL, LUI, REGIMM: r = b;
            COP0:  r = a;
            SPE2: begin
                prod = 64'(sa * sb);
                r = prod[31:0];
            end
            SPE: begin
                case (p.acode)
                    ADD, SUB: begin
                        s = (p.acode == ADD) ? sa + sb : sa - sb;
                        r = s[31:0];
                        ov = s > SMAX || s < SMIN;
                    end
                    ADDU: r = a + b;
                    SUBU: r = a - b;
                    AND_: r = a & b;
                    OR_:  r = a | b;
                    XOR_: r = a ^ b;
                    NOR_: r = ~(a | b);
                    SLL:  r = b << a[4:0];
                    SRA:  r = $signed(b) >>> a[4:0];
                    SRLV: r = b >> a[4:0];
                    SLT:  r = (sa < sb) ? 32'd1 : 32'd0;
                    SLTU: r = (a < b) ? 32'd1 : 32'd0;
                    JALR: r = b;
                    MFHI: r = m_hi;
                    MFLO: r = m_lo;
                    MULT, MULTU: begin
                        prod = (p.acode == MULT) ? 64'(sa * sb) : {32'b0, a} * {32'b0, b};
                        {m_hi, m_lo} = prod;
                        e.chk_hilo = 1'b1;
                    end
                    DIV: begin
                        if (b == 0) begin
                            m_lo = a[31] ? 32'd1 : 32'hffffffff; // negated all ones
                            m_hi = a;
                        end else begin
                            s = sa / sb;
                            m_lo = s[31:0];
                            s = sa % sb;
                            m_hi = s[31:0];
                        end
                        e.chk_hilo = 1'b1;
                    end
                    DIVU: begin
                        m_lo = (b == 0) ? 32'hffffffff : a / b;
                        m_hi = (b == 0) ? a : a % b;
                        e.chk_hilo = 1'b1;
                    end
                    default: r = '0;
                endcase
            end
            default: r = '0;
        endcase
        e.pkt.pc = p.pc;
        e.pkt.val3 = r;
        e.pkt.valt = p.valt;
        e.pkt.icode = p.icode;
        e.pkt.acode = p.acode;
        e.pkt.dst = p.dst;
        e.pkt.in_delay_slot = p.in_delay_slot;
        e.pkt.exc_code = p.exc_code[5] ? p.exc_code : (ov ? EXC_OV : EXC_NONE);
        e.hi = m_hi;
        e.lo = m_lo;
    endtask

    // reads pre-edge values, then updates the model
    task automatic tick(output logic acc);
        logic wr_exp;
        @(posedge clk);
        if (chk_valid) compare_out(out_exp.pkt);
        // write strobes only in the cycle a hilo op leaves E
        wr_exp = !stall_req && e_exp.chk_hilo;
        check32("hilo_out.hi_write", 32'(hilo_out.hi_write), 32'(wr_exp));
        check32("hilo_out.lo_write", 32'(hilo_out.lo_write), 32'(wr_exp));
        if (stall_req) begin
            out_exp = '0;
        end else begin
            out_exp = e_exp;
            if (e_exp.chk_hilo) begin
                check32("hilo_out.hi", hilo_out.hi, e_exp.hi);
                check32("hilo_out.lo", hilo_out.lo, e_exp.lo);
            end
        end
        chk_valid = 1'b1;
        acc = !stall_req;
        if (acc) begin
            if (bubble) e_exp = '0;
            else predict(in_pkt, e_exp);
        end
    endtask

    task automatic send(input id_ex_t p, input logic b);
        logic acc;
        int   n;
        in_pkt <= p;
        bubble <= b;
        n = 0;
        acc = 1'b0;
        while (!acc) begin
            tick(acc);
            n++;
            if (!acc && n > DIV_CYCLES + 8) begin
                $display("timeout: stall_req stayed high for %0d cycles", n);
                fail_run();
            end
        end
    endtask

    function automatic id_ex_t make_pkt(input logic [5:0] ic, input logic [5:0] ac,
                                        input logic [31:0] a, input logic [31:0] b);
        id_ex_t      p;
        logic [31:0] t;
        t = rnd();
        p.pc = rnd();
        p.valt = rnd();
        p.val1 = a;
        p.val2 = b;
        p.icode = ic;
        p.acode = ac;
        p.exc_code = EXC_NONE;
        p.dst = t[4:0];
        p.rt = t[9:5];
        p.rs = t[14:10];
        p.in_delay_slot = t[15];
        return p;
    endfunction

    function automatic id_ex_t rand_pkt();
        id_ex_t      p;
        logic [11:0] op;
        logic [31:0] t;
        op = OP_TABLE[rnd() % NUM_OPS];
        p = make_pkt(op[11:6], op[5:0], rnd(), rnd());
        t = rnd();
        if (p.icode == REGIMM) p.rt = t[0] ? BGEZAL : BLTZAL;
        if (t[4:1] == 4'd0) p.val2 = '0; // zero divisor now and then
        if (t[7:5] == 3'd0) p.exc_code = {1'b1, t[12:8]};
        return p;
    endfunction

    initial begin
        resetn = 1'b0;
        in_pkt = '0;
        bubble = 1'b0;
        chk_valid = 1'b0;
        e_exp = '0;
        out_exp = '0;
        m_hi = '0;
        m_lo = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        send(make_pkt(SPE, MULT, -32'sd7, 32'd9), 1'b0);
        send(make_pkt(SPE, MFHI, 32'd0, 32'd0), 1'b0);
        send(make_pkt(SPE, MFLO, 32'd0, 32'd0), 1'b0);
        send(make_pkt(SPE, DIVU, 32'd100, 32'd0), 1'b0);
        send(make_pkt(SPE, MFHI, 32'd0, 32'd0), 1'b0);
        send(make_pkt(SPE, DIV, -32'sd7, 32'd2), 1'b0);
        send(make_pkt(SPE, MFLO, 32'd0, 32'd0), 1'b0);
        send(make_pkt(SPE2, MUL, -32'sd3, 32'd5), 1'b0);
        send(make_pkt(SPE, MFHI, 32'd0, 32'd0), 1'b0);
        send(make_pkt(SPE, ADD, 32'h7fffffff, 32'd1), 1'b0);
        send(make_pkt(SPE, SUBU, 32'd0, 32'd1), 1'b0);
        send(make_pkt(SPE, ADD, 32'd1, 32'd2), 1'b1);

        for (int i = 0; i < NUM_PKTS; i++) begin
            send(rand_pkt(), (rnd() % 10) == 0);
        end
        repeat (4) send('0, 1'b0); // drain

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/isa_pkg.sv
source/pipe_pkg.sv
source/stage_reg.sv
source/exec_alu.sv
source/mul_multicycle.sv
source/div_multicycle.sv
source/muldiv_unit.sv
source/execute_stage.sv
test/execute_stage_props.sv
test/execute_stage_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
